//--- rv_core.f
rv_pkg.sv
rv_decode_if.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_commit.sv
rv_core.sv
rv_core_assertions.sv
rv_core_tb.sv

//--- rv_core_tb.sv
`default_nettype none

module rv_core_tb
  import rv_pkg::*;
();

  logic  clk;
  logic  rst;
  word_t insn;
  word_t pc;
  logic  halt;
  logic  illegal;

  word_t       model [num_regs];
  word_t       cur_pc;
  logic [15:0] lfsr;
  int          errors;
  int          err_mark;
  int          tests_passed;
  int          tests_failed;

  rv_core rv_core_inst (
    .clk (clk), .rst (rst), .pc (pc), .insn (insn), .halt (halt), .illegal (illegal)
  );

  bind rv_core rv_core_assertions assertions_inst (
    .clk (clk), .rst (rst), .pc (pc), .insn (insn), .halt (halt), .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // poll for a clock edge, gives up after three periods
  task automatic wait_edge(input logic level);
    int n;
    n = 0;
    while (clk !== !level && n < 120) begin
      #1;
      n++;
    end
    while (clk !== level && n < 120) begin
      #1;
      n++;
    end
    if (n >= 120) begin
      $display("timeout: the clock stopped toggling at time %0t", $time);
      $display("Simulation failed");
      $finish;
    end
  endtask

  task automatic check(input word_t actual, input word_t expected, input string msg);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic word_t rand_bits(input int n);
    word_t v;
    logic  fb;
    int    i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return word_t'($signed(a) < $signed(b));
      3'd3: return word_t'(a < b);
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // called on a falling edge, returns on the next one
  task automatic exec_insn(input word_t w, input word_t next_pc, input logic exp_halt,
                           input logic exp_illegal, input string what);
    insn = w;
    wait_edge(1'b1);
    check(word_t'(halt), word_t'(exp_halt), {what, " halt"});
    check(word_t'(illegal), word_t'(exp_illegal), {what, " illegal"});
    wait_edge(1'b0);
    check(pc, next_pc, {what, " pc"});
    cur_pc = next_pc;
  endtask

  task automatic load_reg(input reg_addr_t rd, input word_t v);
    word_t hi;
    hi = (v + 32'h800) >> 12;
    exec_insn({hi[19:0], rd, op_lui}, cur_pc + 4, 1'b0, 1'b0, "lui");
    exec_insn({v[11:0], rd, f3_add, rd, op_imm}, cur_pc + 4, 1'b0, 1'b0, "addi");
    if (rd != 0) model[rd] = v;
  endtask

  // a taken beq against x31 holding the expected value
  task automatic observe_reg(input reg_addr_t rs, input string what);
    load_reg(5'd31, model[rs]);
    exec_insn(enc_b(13'd8, 5'd31, rs, f3_beq), cur_pc + 8, 1'b0, 1'b0, what);
  endtask

  task automatic imm_op(input logic [2:0] f3, input word_t a, input logic [11:0] imm);
    logic alt;
    alt = (f3 == f3_sr) && imm[10];
    load_reg(5'd11, a);
    exec_insn({imm, 5'd11, f3, 5'd10, op_imm}, cur_pc + 4, 1'b0, 1'b0, "imm op");
    model[10] = alu_ref(f3, alt, a, {{20{imm[11]}}, imm});
    observe_reg(5'd10, $sformatf("imm op f3=%0d alt=%0d", f3, alt));
  endtask

  task automatic reg_op(input logic [2:0] f3, input logic alt, input word_t a, input word_t b);
    load_reg(5'd11, a);
    load_reg(5'd12, b);
    exec_insn({(alt ? f7_alt : f7_base), 5'd12, 5'd11, f3, 5'd10, op_reg}, cur_pc + 4,
              1'b0, 1'b0, "reg op");
    model[10] = alu_ref(f3, alt, a, b);
    observe_reg(5'd10, $sformatf("reg op f3=%0d alt=%0d", f3, alt));
  endtask

  task automatic branch_op(input logic [2:0] f3, input word_t a, input word_t b, input int off);
    word_t target;
    load_reg(5'd11, a);
    load_reg(5'd12, b);
    target = br_ref(f3, a, b) ? cur_pc + word_t'(off) : cur_pc + 4;
    exec_insn(enc_b(off[12:0], 5'd12, 5'd11, f3), target, 1'b0, 1'b0,
              $sformatf("branch f3=%0d", f3));
  endtask

  task automatic reset_and_nops();
    check(pc, '0, "pc after reset");
    check(word_t'(halt), '0, "halt after reset");
    check(word_t'(illegal), '0, "illegal after reset");
    repeat (3) exec_insn(32'h0000_0013, cur_pc + 4, 1'b0, 1'b0, "nop");
  endtask

  task automatic imm_ops();
    word_t       a;
    logic [19:0] u20;
    logic [11:0] imm;
    logic [4:0]  sh;
    int          k;
    for (k = 0; k < 3; k++) begin
      u20 = 20'(rand_bits(20));
      exec_insn({u20, 5'd10, op_lui}, cur_pc + 4, 1'b0, 1'b0, "lui");
      model[10] = {u20, 12'h000};
      observe_reg(5'd10, "lui");
      a = rand_bits(32);
      // negative source for srai on pass 1
      if (k == 1) a[31] = 1'b1;
      imm = 12'(rand_bits(12));
      if (k != 0) imm[11] = 1'b1;
      imm_op(f3_add, a, imm);
      imm_op(f3_slt, a, imm);
      imm_op(f3_sltu, a, imm);
      imm_op(f3_xor, a, imm);
      imm_op(f3_or, a, imm);
      imm_op(f3_and, a, imm);
      sh = 5'(rand_bits(5));
      imm_op(f3_sll, a, {7'b0, sh});
      imm_op(f3_sr, a, {7'b0, sh});
      imm_op(f3_sr, a, {f7_alt, sh});
    end
  endtask

  task automatic reg_ops();
    word_t a;
    word_t b;
    int    k;
    int    f;
    for (k = 0; k < 3; k++) begin
      a = (k == 0) ? rand_bits(32) : (k == 1) ? 32'h8000_0000 : 32'hFFFF_FFFF;
      b = (k == 0) ? rand_bits(32) : (k == 1) ? 32'hFFFF_FFFF : 32'h8000_0000;
      for (f = 0; f < 8; f++) reg_op(f[2:0], 1'b0, a, b);
      reg_op(f3_add, 1'b1, a, b);
      reg_op(f3_sr, 1'b1, a, b);
    end
  endtask

  task automatic branch_ops();
    int f;
    for (f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      // signed and unsigned order disagree on this pair
      branch_op(f[2:0], 32'h8000_0000, 32'h0000_0001, 16);
      branch_op(f[2:0], 32'h0000_0001, 32'h8000_0000, -12);
      branch_op(f[2:0], 32'h0000_0001, 32'h0000_0001, 20);
    end
  endtask

  task automatic x0_discard();
    exec_insn({12'd123, 5'd0, f3_add, 5'd0, op_imm}, cur_pc + 4, 1'b0, 1'b0, "addi x0");
    load_reg(5'd5, '0);
    exec_insn(enc_b(13'd8, 5'd5, 5'd0, f3_beq), cur_pc + 8, 1'b0, 1'b0, "beq x0, x5");
  endtask

  task automatic halt_and_illegal();
    load_reg(5'd7, 32'h1234_5678);
    exec_insn(32'h0000_0073, cur_pc + 4, 1'b1, 1'b0, "ecall");
    exec_insn({12'd0, 5'd0, 3'b010, 5'd7, op_load}, cur_pc + 4, 1'b0, 1'b1, "lw x7");
    // equal operands, would be taken if decoded as a branch
    exec_insn(enc_b(13'd8, 5'd7, 5'd7, 3'b010), cur_pc + 4, 1'b0, 1'b1, "branch funct3 2");
    exec_insn(32'h0010_0073, cur_pc + 4, 1'b0, 1'b1, "ebreak");
    observe_reg(5'd7, "x7 after illegal");
  endtask

  task automatic report(input string name);
    if (errors == err_mark) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    rst = 1'b1;
    // addi x0, x0, 0
    insn = 32'h0000_0013;
    lfsr = 16'd17418;
    cur_pc = '0;
    errors = 0;
    err_mark = 0;
    tests_passed = 0;
    tests_failed = 0;
    foreach (model[i]) model[i] = '0;
    repeat (8) wait_edge(1'b1);
    wait_edge(1'b0);
    rst = 1'b0;
    reset_and_nops();
    report("reset and nops");
    imm_ops();
    report("lui and immediate ops");
    reg_ops();
    report("register ops");
    branch_ops();
    report("branches");
    x0_discard();
    report("x0 writes");
    halt_and_illegal();
    report("halt and illegal");
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0 && rv_core_inst.assertions_inst.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core_assertions.sv
`default_nettype none

module rv_core_assertions
  import rv_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input word_t pc,
  input word_t insn,
  input logic  halt,
  input logic  illegal
);

  // number of assertion failures so far
  int fail_count = 0;

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("pc is not word aligned");
    end

  // halt only for the exact ecall word, and never together with illegal
  halt_illegal_excl: assert property (@(posedge clk)
    halt == (insn == 32'h0000_0073) && !(halt && illegal))
    else begin
      fail_count++;
      $error("halt does not match ecall or is high together with illegal");
    end

  pc_reset: assert property (@(posedge clk) rst |=> pc == '0)
    else begin
      fail_count++;
      $error("pc not zero after reset");
    end

  // anything that is not a branch falls through
  pc_step: assert property (@(posedge clk) disable iff (rst)
    insn[6:0] != op_branch |=> pc == $past(pc) + 32'd4)
    else begin
      fail_count++;
      $error("pc did not advance by 4");
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  output word_t pc,
  input  word_t insn,
  output logic  halt,
  output logic  illegal
);

  word_t rs1_data;
  word_t rs2_data;
  word_t result;
  logic  branch_taken;

  rv_decode_if dec_if ();

  rv_decoder decoder_inst (
    .insn (insn),
    .dec  (dec_if.decoder)
  );

  rv_regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .rf       (dec_if.regfile),
    .wr_data  (result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute execute_inst (
    .ex           (dec_if.execute),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (result),
    .branch_taken (branch_taken)
  );

  rv_commit commit_inst (
    .clk          (clk),
    .rst          (rst),
    .cm           (dec_if.commit),
    .branch_taken (branch_taken),
    .pc           (pc)
  );

  // status levels straight from decode
  assign halt    = dec_if.halt;
  assign illegal = dec_if.illegal;

endmodule

`default_nettype wire

//--- rv_commit.sv
`default_nettype none

module rv_commit
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  rv_decode_if.commit cm,
  input  logic  branch_taken,
  output word_t pc
);

  word_t pc_q;
  word_t pc_plus4;
  word_t br_target;
  word_t next_pc;

  assign pc_plus4  = pc_q + 32'd4;
  assign br_target = pc_q + cm.imm;

  // halt and illegal fall through to pc + 4
  assign next_pc = (cm.op_class == cls_branch && branch_taken) ? br_target : pc_plus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= next_pc;
    end
  end

  assign pc = pc_q;

endmodule

`default_nettype wire

//--- rv_execute.sv
`default_nettype none

module rv_execute
  import rv_pkg::*;
(
  rv_decode_if.execute ex,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t result,
  output logic  branch_taken
);

  word_t      op_b;
  word_t      alu_out;
  logic [4:0] shamt;
  logic       cond;

  // register ops take rs2, immediate ops the immediate
  assign op_b  = (ex.op_class == cls_reg) ? rs2_data : ex.imm;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ex.funct3)
      f3_add:  alu_out = ex.alt ? rs1_data - op_b : rs1_data + op_b;
      f3_sll:  alu_out = rs1_data << shamt;
      f3_slt:  alu_out = {31'b0, $signed(rs1_data) < $signed(op_b)};
      f3_sltu: alu_out = {31'b0, rs1_data < op_b};
      f3_xor:  alu_out = rs1_data ^ op_b;
      f3_sr: begin
        if (ex.alt) begin
          alu_out = $unsigned($signed(rs1_data) >>> shamt);
        end else begin
          alu_out = rs1_data >> shamt;
        end
      end
      f3_or:   alu_out = rs1_data | op_b;
      f3_and:  alu_out = rs1_data & op_b;
      default: alu_out = '0;
    endcase
  end

  // lui just passes the upper immediate
  assign result = (ex.op_class == cls_lui) ? ex.imm : alu_out;

  // branch compare always on the two registers
  always_comb begin
    case (ex.funct3)
      f3_beq:  cond = (rs1_data == rs2_data);
      f3_bne:  cond = (rs1_data != rs2_data);
      f3_blt:  cond = $signed(rs1_data) < $signed(rs2_data);
      f3_bge:  cond = $signed(rs1_data) >= $signed(rs2_data);
      f3_bltu: cond = rs1_data < rs2_data;
      f3_bgeu: cond = rs1_data >= rs2_data;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = (ex.op_class == cls_branch) && cond;

endmodule

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none

module rv_regfile
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  rv_decode_if.regfile rf,
  input  word_t wr_data,
  output word_t rs1_data,
  output word_t rs2_data
);

  // x0 has no storage
  word_t regs [1:num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wb_en && rf.rd != '0) begin
      regs[rf.rd] <= wr_data;
    end
  end

  // two async read ports
  assign rs1_data = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
  assign rs2_data = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

endmodule

`default_nettype wire

//--- rv_decoder.sv
`default_nettype none

module rv_decoder
  import rv_pkg::*;
(
  input  word_t   insn,
  rv_decode_if.decoder dec
);

  rv_insn_u  ins;
  op_class_e cls;
  logic      is_ecall;
  logic      br_f3_ok;
  logic      alt_bit;
  word_t     imm_i;
  word_t     imm_b;
  word_t     imm_u;

  assign ins = insn;

  // ecall has every bit above the opcode clear
  assign is_ecall = ({ins.u_fmt.imm20, ins.u_fmt.rd} == '0);

  // funct3 2 and 3 are holes in the branch space
  assign br_f3_ok = ins.b_fmt.funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};

  // funct7 bit 5 only
  assign alt_bit = (ins.r_fmt.funct7 & f7_alt) != f7_base;

  assign imm_i = {{20{ins.i_fmt.imm12[11]}}, ins.i_fmt.imm12};
  assign imm_u = {ins.u_fmt.imm20, 12'b0};
  // B offset bits are scattered over the S-style fields
  assign imm_b = {{20{ins.b_fmt.imm_hi7[6]}}, ins.b_fmt.imm_lo5[0], ins.b_fmt.imm_hi7[5:0],
                  ins.b_fmt.imm_lo5[4:1], 1'b0};

  always_comb begin
    case (ins.r_fmt.opcode)
      op_lui:    cls = cls_lui;
      op_imm:    cls = cls_imm;
      op_reg:    cls = cls_reg;
      op_branch: cls = br_f3_ok ? cls_branch : cls_illegal;
      op_system: cls = is_ecall ? cls_system : cls_illegal;
      // valid RV32I, but not handled by this core
      op_load, op_store, op_jal, op_jalr, op_auipc, op_misc_mem: cls = cls_illegal;
      default:   cls = cls_illegal;
    endcase
  end

  always_comb begin
    case (cls)
      cls_lui:    dec.imm = imm_u;
      cls_imm:    dec.imm = imm_i;
      cls_branch: dec.imm = imm_b;
      default:    dec.imm = '0;
    endcase
  end

  assign dec.rs1      = ins.r_fmt.rs1;
  assign dec.rs2      = ins.r_fmt.rs2;
  assign dec.rd       = ins.i_fmt.rd;
  assign dec.funct3   = ins.r_fmt.funct3;
  assign dec.op_class = cls;

  // immediate bit 30 is payload for everything but srai
  assign dec.alt = alt_bit &&
                   ((cls == cls_reg) || (cls == cls_imm && ins.i_fmt.funct3 == f3_sr));

  assign dec.wb_en   = (cls == cls_lui) || (cls == cls_imm) || (cls == cls_reg);
  assign dec.halt    = (cls == cls_system);
  assign dec.illegal = (cls == cls_illegal);

endmodule

`default_nettype wire

//--- rv_decode_if.sv
`default_nettype none

interface rv_decode_if
  import rv_pkg::*;
();

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  op_class_e op_class;
  logic [2:0] funct3;
  // sub or arithmetic shift
  logic alt;
  word_t imm;
  logic wb_en;
  logic halt;
  logic illegal;

  modport decoder (
    output rs1, rs2, rd, op_class, funct3, alt, imm, wb_en, halt, illegal
  );

  modport regfile (input rs1, rs2, rd, wb_en);

  modport execute (input op_class, funct3, alt, imm);

  modport commit (input op_class, imm);

endinterface

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // base opcode map
  localparam logic [6:0] op_load     = 7'b00_000_11;
  localparam logic [6:0] op_store    = 7'b01_000_11;
  localparam logic [6:0] op_branch   = 7'b11_000_11;
  localparam logic [6:0] op_jalr     = 7'b11_001_11;
  localparam logic [6:0] op_misc_mem = 7'b00_011_11;
  localparam logic [6:0] op_jal      = 7'b11_011_11;
  localparam logic [6:0] op_imm      = 7'b00_100_11;
  localparam logic [6:0] op_reg      = 7'b01_100_11;
  localparam logic [6:0] op_system   = 7'b11_100_11;
  localparam logic [6:0] op_auipc    = 7'b00_101_11;
  localparam logic [6:0] op_lui      = 7'b01_101_11;

  // arithmetic funct3, shared by register and immediate forms
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  typedef enum logic [2:0] {
    cls_lui,
    cls_imm,
    cls_reg,
    cls_branch,
    cls_system,
    cls_illegal
  } op_class_e;

  // one instruction word, four ways of slicing it
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i_fmt;
    // same split as S format
    struct packed {
      logic [6:0] imm_hi7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo5;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm20;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } u_fmt;
  } rv_insn_u;

endpackage

`default_nettype wire
